// ==== include/apb_subsys_cfg.svh ====
// Widths, counts, page map and register offsets shared by the APB subsystem, included where needed
`ifndef APB_SUBSYS_CFG_SVH
`define APB_SUBSYS_CFG_SVH

`define APB_ADDR_W        32
`define APB_DATA_W        32
`define NUM_GPIO          32
`define PWM_CHANNELS      4
`define PWM_CNT_W         16

// Address bits that pick a peripheral page
`define PAGE_MSB          15
`define PAGE_LSB          12
`define PAGE_GPIO         4'd0
`define PAGE_PWM          4'd1
`define PAGE_SOCCTRL      4'd2

`define GPIO_DIR          12'h000
`define GPIO_OUT          12'h004
`define GPIO_IN           12'h008
`define GPIO_INT_EN       12'h00C
`define GPIO_INT_STATUS   12'h010

`define PWM_PERIOD        12'h000
`define PWM_CTRL          12'h004
// One threshold word per channel, 4 bytes apart
`define PWM_THRESH_BASE   12'h010

`define SOC_CLUSTER_CTRL  12'h000
`define SOC_INFO          12'h004

`endif

// ==== hw/apb_bus_pkg.sv ====
// APB bus types for the peripheral subsystem, imported by the decoder and the register blocks
`default_nettype none

`include "apb_subsys_cfg.svh"

package apb_bus_pkg;

   // Full APB address
   typedef logic [`APB_ADDR_W-1:0] apb_addr_t;

   // Read and write data word
   typedef logic [`APB_DATA_W-1:0] apb_data_t;

   // Page field that selects a peripheral
   typedef logic [`PAGE_MSB-`PAGE_LSB:0] apb_page_t;

   // Register offset inside a page
   typedef logic [`PAGE_LSB-1:0] apb_offs_t;

endpackage

`default_nettype wire

// ==== hw/periph_pkg.sv ====
// Peripheral types for GPIO and PWM, imported by the peripheral blocks and the top level
`default_nettype none

`include "apb_subsys_cfg.svh"

package periph_pkg;

   // One bit per GPIO pin
   typedef logic [`NUM_GPIO-1:0] gpio_vec_t;

   // PWM counter, period and threshold value
   typedef logic [`PWM_CNT_W-1:0] pwm_cnt_t;

   // One bit per PWM channel
   typedef logic [`PWM_CHANNELS-1:0] pwm_ch_vec_t;

   // All channel thresholds, channel 0 in the low bits
   typedef logic [`PWM_CHANNELS*`PWM_CNT_W-1:0] pwm_thresh_t;

   // Timer run state
   typedef enum logic {
      PWM_IDLE,
      PWM_RUN
   } pwm_state_t;

endpackage

`default_nettype wire

// ==== hw/apb_periph_decoder.sv ====
// APB page decoder that selects GPIO, PWM or SoC control and returns the slave response
`timescale 1ns/1ps
`default_nettype none

`include "apb_subsys_cfg.svh"

module apb_periph_decoder
   import apb_bus_pkg::*;
(
   input  wire logic      clk_i,
   input  wire logic      reset_i,
   input  wire logic      psel_i,
   input  wire logic      penable_i,
   input  wire apb_addr_t paddr_i,
   input  wire apb_data_t gpio_rdata_i,
   input  wire apb_data_t pwm_rdata_i,
   input  wire apb_data_t soc_rdata_i,
   output logic           gpio_sel_o,
   output logic           pwm_sel_o,
   output logic           soc_sel_o,
   output apb_data_t      prdata_o,
   output logic           pready_o,
   output logic           pslverr_o
);

   apb_page_t page;
   logic      mapped;

   assign page = paddr_i[`PAGE_MSB:`PAGE_LSB];

   assign gpio_sel_o = psel_i && (page == `PAGE_GPIO);
   assign pwm_sel_o  = psel_i && (page == `PAGE_PWM);
   assign soc_sel_o  = psel_i && (page == `PAGE_SOCCTRL);

   assign mapped = gpio_sel_o || pwm_sel_o || soc_sel_o;

   // All slaves are zero-wait
   assign pready_o  = psel_i && penable_i;
   assign pslverr_o = psel_i && penable_i && !mapped;

   always_comb begin
      case (page)
         `PAGE_GPIO:    prdata_o = gpio_rdata_i;
         `PAGE_PWM:     prdata_o = pwm_rdata_i;
         `PAGE_SOCCTRL: prdata_o = soc_rdata_i;
         default:       prdata_o = '0;
      endcase
   end

   a_enable_needs_sel: assert property (@(posedge clk_i) disable iff (reset_i)
      penable_i |-> psel_i);

   // Setup phase must be followed by an access to the same address
   a_setup_to_access: assert property (@(posedge clk_i) disable iff (reset_i)
      (psel_i && !penable_i) |=> (psel_i && penable_i && $stable(paddr_i)));

endmodule

`default_nettype wire

// ==== hw/gpio_ctrl.sv ====
// GPIO controller with direction and output registers, synchronized inputs and edge interrupts
`timescale 1ns/1ps
`default_nettype none

`include "apb_subsys_cfg.svh"

module gpio_ctrl
   import apb_bus_pkg::*, periph_pkg::*;
(
   input  wire logic      clk_i,
   input  wire logic      reset_i,
   input  wire logic      sel_i,
   input  wire logic      penable_i,
   input  wire logic      pwrite_i,
   input  wire apb_offs_t addr_i,
   input  wire apb_data_t wdata_i,
   input  wire gpio_vec_t gpio_in_i,
   output apb_data_t      rdata_o,
   output gpio_vec_t      gpio_out_o,
   output gpio_vec_t      gpio_oe_o,
   output logic           irq_o
);

   gpio_vec_t dir_q;
   gpio_vec_t out_q;
   gpio_vec_t int_en_q;
   gpio_vec_t status_q;
   gpio_vec_t in_meta_q;
   gpio_vec_t in_sync_q;
   gpio_vec_t in_prev_q;
   gpio_vec_t rise;
   logic      wr_en;

   assign wr_en = sel_i && penable_i && pwrite_i;
   assign rise  = in_sync_q & ~in_prev_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         dir_q     <= '0;
         out_q     <= '0;
         int_en_q  <= '0;
         status_q  <= '0;
         in_meta_q <= '0;
         in_sync_q <= '0;
         in_prev_q <= '0;
         irq_o     <= 1'b0;
      end else begin
         in_meta_q <= gpio_in_i;
         in_sync_q <= in_meta_q;
         in_prev_q <= in_sync_q;
         irq_o     <= |(status_q & int_en_q);
         // New edges win over a clear in the same cycle
         if (wr_en && addr_i == `GPIO_INT_STATUS)
            status_q <= (status_q & ~wdata_i[`NUM_GPIO-1:0]) | rise;
         else
            status_q <= status_q | rise;
         if (wr_en) begin
            case (addr_i)
               `GPIO_DIR:    dir_q    <= wdata_i[`NUM_GPIO-1:0];
               `GPIO_OUT:    out_q    <= wdata_i[`NUM_GPIO-1:0];
               `GPIO_INT_EN: int_en_q <= wdata_i[`NUM_GPIO-1:0];
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (addr_i)
         `GPIO_DIR:        rdata_o = apb_data_t'(dir_q);
         `GPIO_OUT:        rdata_o = apb_data_t'(out_q);
         `GPIO_IN:         rdata_o = apb_data_t'(in_sync_q);
         `GPIO_INT_EN:     rdata_o = apb_data_t'(int_en_q);
         `GPIO_INT_STATUS: rdata_o = apb_data_t'(status_q);
         default:          rdata_o = '0;
      endcase
   end

   assign gpio_out_o = out_q;
   assign gpio_oe_o  = dir_q;

endmodule

`default_nettype wire

// ==== hw/pwm_regs.sv ====
// PWM configuration registers on APB, feeding period, enable and thresholds to the PWM core
`timescale 1ns/1ps
`default_nettype none

`include "apb_subsys_cfg.svh"

module pwm_regs
   import apb_bus_pkg::*, periph_pkg::*;
(
   input  wire logic      clk_i,
   input  wire logic      reset_i,
   input  wire logic      sel_i,
   input  wire logic      penable_i,
   input  wire logic      pwrite_i,
   input  wire apb_offs_t addr_i,
   input  wire apb_data_t wdata_i,
   output apb_data_t      rdata_o,
   output logic           pwm_en_o,
   output pwm_cnt_t       period_o,
   output pwm_thresh_t    thresh_o
);

   pwm_cnt_t period_q;
   pwm_cnt_t thresh_q [`PWM_CHANNELS];
   logic     en_q;
   logic     wr_en;

   assign wr_en = sel_i && penable_i && pwrite_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         period_q <= '0;
         en_q     <= 1'b0;
         for (int n = 0; n < `PWM_CHANNELS; n++)
            thresh_q[n] <= '0;
      end else if (wr_en) begin
         case (addr_i)
            `PWM_PERIOD: period_q <= wdata_i[`PWM_CNT_W-1:0];
            `PWM_CTRL:   en_q     <= wdata_i[0];
            default: ;
         endcase
         for (int n = 0; n < `PWM_CHANNELS; n++)
            if (addr_i == apb_offs_t'(`PWM_THRESH_BASE + 4 * n))
               thresh_q[n] <= wdata_i[`PWM_CNT_W-1:0];
      end
   end

   always_comb begin
      rdata_o = '0;
      case (addr_i)
         `PWM_PERIOD: rdata_o = apb_data_t'(period_q);
         `PWM_CTRL:   rdata_o = apb_data_t'(en_q);
         default: ;
      endcase
      for (int n = 0; n < `PWM_CHANNELS; n++)
         if (addr_i == apb_offs_t'(`PWM_THRESH_BASE + 4 * n))
            rdata_o = apb_data_t'(thresh_q[n]);
   end

   // Channel 0 in the low bits
   for (genvar g = 0; g < `PWM_CHANNELS; g++) begin : g_flat
      assign thresh_o[g*`PWM_CNT_W +: `PWM_CNT_W] = thresh_q[g];
   end

   assign pwm_en_o = en_q;
   assign period_o = period_q;

endmodule

`default_nettype wire

// ==== hw/pwm_core.sv ====
// Shared PWM counter with per-channel compare outputs, configured by the PWM register block
`timescale 1ns/1ps
`default_nettype none

`include "apb_subsys_cfg.svh"

module pwm_core
   import periph_pkg::*;
(
   input  wire logic        clk_i,
   input  wire logic        reset_i,
   input  wire logic        pwm_en_i,
   input  wire pwm_cnt_t    period_i,
   input  wire pwm_thresh_t thresh_i,
   output pwm_ch_vec_t      pwm_o
);

   pwm_state_t state_q;
   pwm_cnt_t   cnt_q;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= PWM_IDLE;
         cnt_q   <= '0;
         pwm_o   <= '0;
      end else begin
         case (state_q)
            PWM_IDLE: begin
               cnt_q <= '0;
               if (pwm_en_i)
                  state_q <= PWM_RUN;
            end
            PWM_RUN: begin
               if (!pwm_en_i) begin
                  state_q <= PWM_IDLE;
                  cnt_q   <= '0;
               end else if (cnt_q >= period_i)
                  cnt_q <= '0;
               else
                  cnt_q <= cnt_q + 1'b1;
            end
            default: state_q <= PWM_IDLE;
         endcase
         // Outputs drop together with the enable
         for (int n = 0; n < `PWM_CHANNELS; n++)
            pwm_o[n] <= pwm_en_i && (state_q == PWM_RUN) &&
                        (cnt_q < thresh_i[n*`PWM_CNT_W +: `PWM_CNT_W]);
      end
   end

   a_cnt_in_period: assert property (@(posedge clk_i) disable iff (reset_i)
      (state_q == PWM_RUN && $stable(period_i)) |-> (cnt_q <= period_i));

endmodule

`default_nettype wire

// ==== hw/soc_ctrl_regs.sv ====
// SoC control registers holding the cluster reset, boot mode and fetch enable, plus an info word
`timescale 1ns/1ps
`default_nettype none

`include "apb_subsys_cfg.svh"

module soc_ctrl_regs
   import apb_bus_pkg::*, periph_pkg::*;
(
   input  wire logic      clk_i,
   input  wire logic      reset_i,
   input  wire logic      sel_i,
   input  wire logic      penable_i,
   input  wire logic      pwrite_i,
   input  wire apb_offs_t addr_i,
   input  wire apb_data_t wdata_i,
   output apb_data_t      rdata_o,
   output logic           cluster_rstn_o,
   output logic           cluster_en_sa_boot_o,
   output logic           cluster_fetch_en_o
);

   // Pin count in bits 7:0, channel count in bits 15:8
   localparam apb_data_t INFO_WORD = {16'h0, 8'($bits(pwm_ch_vec_t)), 8'($bits(gpio_vec_t))};

   logic [2:0] ctrl_q;
   logic       wr_en;

   assign wr_en = sel_i && penable_i && pwrite_i;

   // Cleared ctrl holds the cluster in reset
   always_ff @(posedge clk_i) begin
      if (reset_i)
         ctrl_q <= '0;
      else if (wr_en && addr_i == `SOC_CLUSTER_CTRL)
         ctrl_q <= wdata_i[2:0];
   end

   always_comb begin
      case (addr_i)
         `SOC_CLUSTER_CTRL: rdata_o = apb_data_t'(ctrl_q);
         `SOC_INFO:         rdata_o = INFO_WORD;
         default:           rdata_o = '0;
      endcase
   end

   assign cluster_rstn_o       = ctrl_q[0];
   assign cluster_en_sa_boot_o = ctrl_q[1];
   assign cluster_fetch_en_o   = ctrl_q[2];

endmodule

`default_nettype wire

// ==== hw/apb_subsystem.sv ====
// APB peripheral subsystem top level, one APB slave port feeding GPIO, PWM and SoC control
`timescale 1ns/1ps
`default_nettype none

`include "apb_subsys_cfg.svh"

module apb_subsystem
   import apb_bus_pkg::*, periph_pkg::*;
(
   input  wire logic        clk_i,
   input  wire logic        reset_i,
   input  wire logic        psel_i,
   input  wire logic        penable_i,
   input  wire logic        pwrite_i,
   input  wire apb_addr_t   paddr_i,
   input  wire apb_data_t   pwdata_i,
   input  wire gpio_vec_t   gpio_in_i,
   output apb_data_t        prdata_o,
   output logic             pready_o,
   output logic             pslverr_o,
   output gpio_vec_t        gpio_out_o,
   output gpio_vec_t        gpio_oe_o,
   output logic             gpio_irq_o,
   output pwm_ch_vec_t      pwm_o,
   output logic             cluster_rstn_o,
   output logic             cluster_en_sa_boot_o,
   output logic             cluster_fetch_en_o
);

   logic        gpio_sel;
   logic        pwm_sel;
   logic        soc_sel;
   apb_data_t   gpio_rdata;
   apb_data_t   pwm_rdata;
   apb_data_t   soc_rdata;
   logic        pwm_en;
   pwm_cnt_t    pwm_period;
   pwm_thresh_t pwm_thresh;

   apb_periph_decoder i_decoder (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .psel_i       (psel_i),
      .penable_i    (penable_i),
      .paddr_i      (paddr_i),
      .gpio_rdata_i (gpio_rdata),
      .pwm_rdata_i  (pwm_rdata),
      .soc_rdata_i  (soc_rdata),
      .gpio_sel_o   (gpio_sel),
      .pwm_sel_o    (pwm_sel),
      .soc_sel_o    (soc_sel),
      .prdata_o     (prdata_o),
      .pready_o     (pready_o),
      .pslverr_o    (pslverr_o)
   );

   gpio_ctrl i_gpio (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .sel_i      (gpio_sel),
      .penable_i  (penable_i),
      .pwrite_i   (pwrite_i),
      .addr_i     (paddr_i[`PAGE_LSB-1:0]),
      .wdata_i    (pwdata_i),
      .gpio_in_i  (gpio_in_i),
      .rdata_o    (gpio_rdata),
      .gpio_out_o (gpio_out_o),
      .gpio_oe_o  (gpio_oe_o),
      .irq_o      (gpio_irq_o)
   );

   pwm_regs i_pwm_regs (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .sel_i     (pwm_sel),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .addr_i    (paddr_i[`PAGE_LSB-1:0]),
      .wdata_i   (pwdata_i),
      .rdata_o   (pwm_rdata),
      .pwm_en_o  (pwm_en),
      .period_o  (pwm_period),
      .thresh_o  (pwm_thresh)
   );

   pwm_core i_pwm_core (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .pwm_en_i (pwm_en),
      .period_i (pwm_period),
      .thresh_i (pwm_thresh),
      .pwm_o    (pwm_o)
   );

   soc_ctrl_regs i_soc_ctrl (
      .clk_i                (clk_i),
      .reset_i              (reset_i),
      .sel_i                (soc_sel),
      .penable_i            (penable_i),
      .pwrite_i             (pwrite_i),
      .addr_i               (paddr_i[`PAGE_LSB-1:0]),
      .wdata_i              (pwdata_i),
      .rdata_o              (soc_rdata),
      .cluster_rstn_o       (cluster_rstn_o),
      .cluster_en_sa_boot_o (cluster_en_sa_boot_o),
      .cluster_fetch_en_o   (cluster_fetch_en_o)
   );

endmodule

`default_nettype wire

// ==== tests/tb_apb_subsystem.sv ====
// Directed testbench for the APB subsystem, run as top module from the file list
`timescale 1ns/1ps
`default_nettype none

`include "apb_subsys_cfg.svh"

module tb_apb_subsystem
   import apb_bus_pkg::*, periph_pkg::*;
();

   localparam int CLK_PERIOD = 4;
   localparam int SEED = 32'h32c1;
   // Cycle budgets of reset and the five tests, with a margin of 4
   localparam int BUDGET_CYCLES = 4 + 60 + 40 + 100 + 150 + 30;
   localparam int WATCHDOG_NS = BUDGET_CYCLES * CLK_PERIOD * 4;

   logic        clk;
   logic        reset;
   logic        psel;
   logic        penable;
   logic        pwrite;
   apb_addr_t   paddr;
   apb_data_t   pwdata;
   apb_data_t   prdata;
   logic        pready;
   logic        pslverr;
   gpio_vec_t   gpio_in;
   gpio_vec_t   gpio_out;
   gpio_vec_t   gpio_oe;
   logic        gpio_irq;
   pwm_ch_vec_t pwm;
   logic        cluster_rstn;
   logic        cluster_boot;
   logic        cluster_fetch;

   int          n_errors;
   int          n_tests;
   int          n_failed;
   int          seed_dummy;
   logic [2:0]  last_ctrl;
   gpio_vec_t   last_dir;
   int          last_period;

   always #(CLK_PERIOD / 2) clk = ~clk;

   apb_subsystem UUT (
      .clk_i                (clk),
      .reset_i              (reset),
      .psel_i               (psel),
      .penable_i            (penable),
      .pwrite_i             (pwrite),
      .paddr_i              (paddr),
      .pwdata_i             (pwdata),
      .gpio_in_i            (gpio_in),
      .prdata_o             (prdata),
      .pready_o             (pready),
      .pslverr_o            (pslverr),
      .gpio_out_o           (gpio_out),
      .gpio_oe_o            (gpio_oe),
      .gpio_irq_o           (gpio_irq),
      .pwm_o                (pwm),
      .cluster_rstn_o       (cluster_rstn),
      .cluster_en_sa_boot_o (cluster_boot),
      .cluster_fetch_en_o   (cluster_fetch)
   );

   function automatic apb_addr_t reg_addr(input logic [3:0] page, input logic [11:0] offs);
      return {16'h0, page, offs};
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
      n_errors++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
   endtask

   task automatic report_test(input string name, input int errs_before);
      n_tests++;
      if (n_errors != errs_before)
         n_failed++;
      $display("%-24s %s", name, (n_errors == errs_before) ? "passed" : "failed");
   endtask

   // Setup and access cycle, entered and left on a falling edge
   task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                               output apb_data_t rdata);
      logic err_exp;
      err_exp = (addr[`PAGE_MSB:`PAGE_LSB] > `PAGE_SOCCTRL);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      #1;
      if (pready !== 1'b1)
         report_mismatch("pready", 32'(pready), 32'd1);
      if (pslverr !== err_exp)
         report_mismatch("pslverr", 32'(pslverr), 32'(err_exp));
      rdata = prdata;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
      apb_data_t unused_rdata;
      apb_transfer(1'b1, addr, wdata, unused_rdata);
   endtask

   task automatic apb_read_check(input string what, input apb_addr_t addr,
                                 input apb_data_t exp);
      apb_data_t got;
      apb_transfer(1'b0, addr, '0, got);
      if (got !== exp)
         report_mismatch(what, got, exp);
   endtask

   task automatic reset_and_soc_ctrl();
      int         errs;
      logic [2:0] v;
      apb_data_t  info;
      errs = n_errors;
      v    = '0;
      info = {16'h0, 8'(`PWM_CHANNELS), 8'(`NUM_GPIO)};
      if ({cluster_fetch, cluster_boot, cluster_rstn} !== 3'b000)
         report_mismatch("cluster outputs after reset",
                         32'({cluster_fetch, cluster_boot, cluster_rstn}), 32'd0);
      if ((gpio_oe | gpio_out) !== '0)
         report_mismatch("gpio outputs after reset", 32'(gpio_oe | gpio_out), 32'd0);
      if ({gpio_irq, pwm} !== '0)
         report_mismatch("irq and pwm after reset", 32'({gpio_irq, pwm}), 32'd0);
      for (int i = 0; i < 4; i++) begin
         v = 3'($urandom);
         apb_write(reg_addr(`PAGE_SOCCTRL, `SOC_CLUSTER_CTRL), 32'(v));
         if ({cluster_fetch, cluster_boot, cluster_rstn} !== v)
            report_mismatch("cluster outputs",
                            32'({cluster_fetch, cluster_boot, cluster_rstn}), 32'(v));
         apb_read_check("SOC_CLUSTER_CTRL", reg_addr(`PAGE_SOCCTRL, `SOC_CLUSTER_CTRL), 32'(v));
      end
      last_ctrl = v;
      apb_read_check("SOC_INFO", reg_addr(`PAGE_SOCCTRL, `SOC_INFO), info);
      apb_write(reg_addr(`PAGE_SOCCTRL, `SOC_INFO), $urandom);
      apb_read_check("SOC_INFO after write", reg_addr(`PAGE_SOCCTRL, `SOC_INFO), info);
      apb_read_check("SOC_CLUSTER_CTRL kept", reg_addr(`PAGE_SOCCTRL, `SOC_CLUSTER_CTRL), 32'(v));
      report_test("reset and SoC control", errs);
   endtask

   task automatic gpio_outputs();
      int        errs;
      gpio_vec_t dir;
      gpio_vec_t out;
      errs = n_errors;
      dir  = '0;
      for (int i = 0; i < 4; i++) begin
         dir = $urandom;
         out = $urandom;
         apb_write(reg_addr(`PAGE_GPIO, `GPIO_DIR), 32'(dir));
         apb_write(reg_addr(`PAGE_GPIO, `GPIO_OUT), 32'(out));
         if (gpio_oe !== dir)
            report_mismatch("gpio_oe_o", 32'(gpio_oe), 32'(dir));
         if (gpio_out !== out)
            report_mismatch("gpio_out_o", 32'(gpio_out), 32'(out));
         apb_read_check("GPIO_DIR", reg_addr(`PAGE_GPIO, `GPIO_DIR), 32'(dir));
         apb_read_check("GPIO_OUT", reg_addr(`PAGE_GPIO, `GPIO_OUT), 32'(out));
      end
      last_dir = dir;
      report_test("GPIO outputs", errs);
   endtask

   task automatic gpio_inputs_irq();
      int        errs;
      int        cycles;
      gpio_vec_t rnd_in;
      gpio_vec_t en_mask;
      gpio_vec_t pins;
      errs   = n_errors;
      rnd_in = $urandom;
      // Interrupts still disabled, so edges only set status
      gpio_in = rnd_in;
      repeat (3) @(negedge clk);
      apb_read_check("GPIO_IN", reg_addr(`PAGE_GPIO, `GPIO_IN), 32'(rnd_in));
      apb_read_check("GPIO_INT_STATUS", reg_addr(`PAGE_GPIO, `GPIO_INT_STATUS), 32'(rnd_in));
      if (gpio_irq !== 1'b0)
         report_mismatch("gpio_irq_o with no enable", 32'(gpio_irq), 32'd0);
      apb_write(reg_addr(`PAGE_GPIO, `GPIO_INT_STATUS), 32'hFFFF_FFFF);
      gpio_in = '0;
      repeat (3) @(negedge clk);
      apb_read_check("cleared status", reg_addr(`PAGE_GPIO, `GPIO_INT_STATUS), 32'd0);
      // Upper half stays disabled
      en_mask = gpio_vec_t'({16'h0, 16'($urandom)}) | gpio_vec_t'(1);
      apb_write(reg_addr(`PAGE_GPIO, `GPIO_INT_EN), 32'(en_mask));
      pins = en_mask & gpio_vec_t'($urandom);
      if (pins == '0)
         pins = en_mask;
      gpio_in = pins;
      cycles  = 0;
      while (gpio_irq !== 1'b1 && cycles < 10) begin
         @(negedge clk);
         cycles++;
      end
      if (gpio_irq !== 1'b1) begin
         n_errors++;
         $display("gpio_irq_o did not rise after enabled pins went high");
      end else if (cycles != 4)
         report_mismatch("irq latency in cycles", 32'(cycles), 32'd4);
      apb_read_check("status of enabled pins", reg_addr(`PAGE_GPIO, `GPIO_INT_STATUS), 32'(pins));
      apb_write(reg_addr(`PAGE_GPIO, `GPIO_INT_STATUS), 32'(pins));
      @(negedge clk);
      if (gpio_irq !== 1'b0)
         report_mismatch("gpio_irq_o after clear", 32'(gpio_irq), 32'd0);
      apb_read_check("status after clear", reg_addr(`PAGE_GPIO, `GPIO_INT_STATUS), 32'd0);
      gpio_in = '0;
      repeat (3) @(negedge clk);
      pins    = (gpio_vec_t'($urandom) & ~en_mask) | gpio_vec_t'(32'h8000_0000);
      gpio_in = pins;
      repeat (5) begin
         @(negedge clk);
         if (gpio_irq !== 1'b0)
            report_mismatch("gpio_irq_o on disabled pins", 32'(gpio_irq), 32'd0);
      end
      apb_read_check("status of disabled pins", reg_addr(`PAGE_GPIO, `GPIO_INT_STATUS), 32'(pins));
      apb_write(reg_addr(`PAGE_GPIO, `GPIO_INT_STATUS), 32'(pins));
      apb_write(reg_addr(`PAGE_GPIO, `GPIO_INT_EN), 32'd0);
      report_test("GPIO inputs and irq", errs);
   endtask

   task automatic pwm_duty();
      int       errs;
      int       p;
      int       exp;
      int       high_cnt [`PWM_CHANNELS];
      pwm_cnt_t th [`PWM_CHANNELS];
      errs  = n_errors;
      p     = 3 + int'($urandom % 16);
      th[0] = '0;
      th[1] = pwm_cnt_t'(p + 1);
      th[2] = pwm_cnt_t'($urandom % (p + 4));
      th[3] = pwm_cnt_t'($urandom % (p + 4));
      apb_write(reg_addr(`PAGE_PWM, `PWM_PERIOD), 32'(p));
      for (int n = 0; n < `PWM_CHANNELS; n++)
         apb_write(reg_addr(`PAGE_PWM, 12'(`PWM_THRESH_BASE + 4 * n)), 32'(th[n]));
      apb_read_check("PWM_PERIOD", reg_addr(`PAGE_PWM, `PWM_PERIOD), 32'(p));
      apb_read_check("PWM threshold 2", reg_addr(`PAGE_PWM, `PWM_THRESH_BASE + 12'h8), 32'(th[2]));
      apb_write(reg_addr(`PAGE_PWM, `PWM_CTRL), 32'd1);
      repeat (p + 3) @(negedge clk);
      for (int n = 0; n < `PWM_CHANNELS; n++)
         high_cnt[n] = 0;
      for (int c = 0; c < 4 * (p + 1); c++) begin
         @(negedge clk);
         for (int n = 0; n < `PWM_CHANNELS; n++)
            if (pwm[n] === 1'b1)
               high_cnt[n]++;
      end
      for (int n = 0; n < `PWM_CHANNELS; n++) begin
         exp = 4 * ((int'(th[n]) < p + 1) ? int'(th[n]) : p + 1);
         if (high_cnt[n] != exp)
            report_mismatch($sformatf("high cycles of channel %0d", n), 32'(high_cnt[n]),
                            32'(exp));
      end
      apb_write(reg_addr(`PAGE_PWM, `PWM_CTRL), 32'd0);
      @(negedge clk);
      if (pwm !== '0)
         report_mismatch("pwm_o after disable", 32'(pwm), 32'd0);
      apb_read_check("PWM_CTRL", reg_addr(`PAGE_PWM, `PWM_CTRL), 32'd0);
      last_period = p;
      report_test("PWM duty", errs);
   endtask

   task automatic unmapped_page_error();
      int        errs;
      apb_data_t wr_rdata;
      errs = n_errors;
      apb_read_check("page 3 read data", reg_addr(4'd3, 12'h000), 32'd0);
      apb_transfer(1'b1, reg_addr(4'd3, 12'h000), $urandom, wr_rdata);
      if (wr_rdata !== '0)
         report_mismatch("page 3 write read data", wr_rdata, 32'd0);
      apb_read_check("SOC_CLUSTER_CTRL", reg_addr(`PAGE_SOCCTRL, `SOC_CLUSTER_CTRL),
                     32'(last_ctrl));
      apb_read_check("GPIO_DIR", reg_addr(`PAGE_GPIO, `GPIO_DIR), 32'(last_dir));
      apb_read_check("PWM_PERIOD", reg_addr(`PAGE_PWM, `PWM_PERIOD), 32'(last_period));
      if ({cluster_fetch, cluster_boot, cluster_rstn} !== last_ctrl)
         report_mismatch("cluster outputs",
                         32'({cluster_fetch, cluster_boot, cluster_rstn}), 32'(last_ctrl));
      report_test("unmapped page error", errs);
   endtask

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin : main
      clk        = 1'b0;
      reset      = 1'b1;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      gpio_in    = '0;
      n_errors   = 0;
      n_tests    = 0;
      n_failed   = 0;
      seed_dummy = $urandom(SEED);
      repeat (2) @(negedge clk);
      reset = 1'b0;
      reset_and_soc_ctrl();
      gpio_outputs();
      gpio_inputs_irq();
      pwm_duty();
      unmapped_page_error();
      $display("Tests run %0d, tests failed %0d, errors %0d", n_tests, n_failed, n_errors);
      if (n_errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
hw/apb_bus_pkg.sv
hw/periph_pkg.sv
hw/apb_periph_decoder.sv
hw/gpio_ctrl.sv
hw/pwm_regs.sv
hw/pwm_core.sv
hw/soc_ctrl_regs.sv
hw/apb_subsystem.sv
tests/tb_apb_subsystem.sv

// ==== Makefile ====
# Verilator build and run of the APB subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_apb_subsystem
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "NO ERRORS" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
